// ==== filelist.f ====
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/dec_pipe_reg.sv
verilog/inst_decoder.sv
verilog/dec_issue_merge.sv
verilog/ifu_dec_top.sv
testbench/tb_ifu_dec.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f filelist.f --top-module tb_ifu_dec -o tb_ifu_dec \
   && ./obj_dir/tb_ifu_dec | tee sim.log \
   || { echo "build or run error"; exit 1; }

# pass only when the log holds the pass line
grep -q "Everything OK" sim.log \
   && echo "PASS" \
   || { echo "FAIL"; exit 1; }

// ==== testbench/ifu_dec_testdata.txt ====
// fv stall int pc inst br_target br_taken fetch_exc fetch_code hint
// then expected: issue_valid op_class bru_code gr_wen dst_r1 rf_target exception exccode
1 0 0 1c000000 00100c41 07000001 0 0 00 1   1 0 0 1 0 01 0 00 // add.w rd=1
1 0 0 1c000004 00111486 07000002 0 0 00 2   1 0 0 1 0 06 0 00 // sub.w rd=6
1 0 0 1c000008 02804067 07000003 0 0 00 3   1 0 0 1 0 07 0 00 // addi.w
1 0 0 1c00000c 28802049 07000004 0 0 00 4   1 1 0 1 0 09 0 00 // ld.w
1 0 0 1c000010 2980104a 07000005 0 0 00 5   1 2 0 0 0 00 0 00 // st.w
1 0 0 1c000014 50000010 07000009 1 0 00 6   1 3 1 0 0 00 0 00 // b
1 0 0 1c000018 5400002f 0700000e 1 0 00 7   1 3 2 1 1 01 0 00 // bl, rd bits ignored
1 0 0 1c00001c 58000085 07000027 0 0 00 8   1 3 3 0 0 00 0 00 // beq
1 0 0 1c000020 5c0000a3 07000030 1 0 00 9   1 3 3 0 0 00 0 00 // bne
1 0 0 1c000024 002b0005 00000000 0 0 00 a   1 4 0 0 0 00 1 0b // syscall
1 0 0 1c000028 002a0000 00000000 0 0 00 b   1 5 0 0 0 00 1 0c // break
1 0 0 1c00002c 00000000 00000000 0 0 00 c   1 6 0 0 0 00 1 0d // all zero word
1 0 0 1c000030 ffffffff 3fffffff 1 0 00 d   1 6 0 0 0 00 1 0d
1 0 0 1c000034 00108000 00000000 0 0 00 e   1 6 0 0 0 00 1 0d // reg3 opcode outside subset
1 0 1 1c000038 00100c41 00000000 0 0 00 0   1 0 0 1 0 01 1 00 // interrupt on add.w
1 0 0 1c00003c 00100c41 00000000 0 1 08 0   1 0 0 1 0 01 1 08 // fetch fault on add.w
1 0 0 1c000040 002b0005 00000000 0 1 08 0   1 4 0 0 0 00 1 08 // fetch fault beats syscall
1 0 1 1c000044 002b0005 00000000 0 1 08 0   1 4 0 0 0 00 1 00 // interrupt beats both
1 0 1 1c000048 002a0000 00000000 0 0 00 0   1 5 0 0 0 00 1 00
1 0 0 1c00004c 002a0000 00000000 0 1 03 0   1 5 0 0 0 00 1 03
1 0 0 1c000050 ffffffff 00000000 0 1 3f 0   1 6 0 0 0 00 1 3f
1 0 1 1c000054 00000000 00000000 0 0 00 0   1 6 0 0 0 00 1 00
1 0 0 1c000100 001014a3 07000040 1 0 00 5   1 0 0 1 0 03 0 00 // add.w rd=3
1 1 0 1c000104 28802049 07000041 0 0 00 6   1 0 0 1 0 03 0 00 // stall, ld.w dropped
0 1 0 0badc0de 002b0005 00000000 0 1 08 f   1 0 0 1 0 03 0 00
1 1 1 1c000104 28802049 07000041 0 0 00 6   1 0 0 1 0 03 1 00 // interrupt while held
1 0 0 1c000104 28802049 07000041 0 0 00 6   1 1 0 1 0 09 0 00 // released
0 0 0 0badc0de 00100c41 00000000 0 0 00 f   0 1 0 1 0 09 0 00 // bubble
0 0 1 0badc0de 00100c41 00000000 0 0 00 f   0 1 0 1 0 09 1 00
1 1 0 0badc0de 00100c41 00000000 0 0 00 f   0 1 0 1 0 09 0 00 // stall holds the bubble
1 0 0 1c000108 54000000 07000050 1 0 00 2   1 3 2 1 1 01 0 00
0 0 0 0badc0de 00000000 00000000 0 0 00 0   0 3 2 1 1 01 0 00
1 0 0 1c00010c 2980104a 00000000 0 1 08 3   1 2 0 0 0 00 1 08 // st.w with fetch fault

// ==== testbench/tb_ifu_dec.sv ====
module tb_ifu_dec;

   // words per row in the vector file
   // stimulus columns come before the expected ones
   localparam int NUM_COLS = 18;
   localparam int NUM_ROWS = 33;
   // extra words outside the decoded subset
   localparam int NUM_RAND = 24;
   // cycles allowed for any single wait
   localparam int WAIT_LIMIT = 50;

   logic                 clk;
   logic                 rst;
   logic                 fetch_valid;
   pipe_pkg::fetch_pkt_t fetch_pkt;
   logic                 int_except;
   logic                 stall;
   logic                 dec_valid;
   logic                 issue_valid;
   pipe_pkg::issue_pkt_t issue_pkt;

   // raw vectors with NUM_COLS words per row
   logic [31:0] vec_mem [0:NUM_ROWS*NUM_COLS-1];

   // last packet the stage should have taken in
   pipe_pkg::fetch_pkt_t exp_pay;
   logic                 loaded;

   integer seed;

   ifu_dec_top i_dut (
      .clk         (clk),
      .rst         (rst),
      .fetch_valid (fetch_valid),
      .fetch_pkt   (fetch_pkt),
      .dec_valid   (dec_valid),
      .int_except  (int_except),
      .issue_valid (issue_valid),
      .issue_pkt   (issue_pkt),
      .stall       (stall)
   );

   // 100 unit period
   initial begin
      clk = 1'b0;
      forever begin
         #50 clk = ~clk;
      end
   end

   task automatic stop_run();
      $display("Something failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("Fail t=%0t %s expected %h got %h", $time, name, exp, act);
      stop_run();
   endtask

   task automatic check_valid(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         report_mismatch(name, 32'(exp), 32'(act));
      end
   endtask

   task automatic check_op(input isa_pkg::dec_op_t exp, input isa_pkg::dec_op_t act);
      if (act !== exp) begin
         $display("Fail t=%0t issue_pkt.op expected %h got %h", $time, exp, act);
         stop_run();
      end
   endtask

   task automatic check_exc(input logic exp_exc, input logic [isa_pkg::EXC_W-1:0] exp_code,
                            input logic act_exc, input logic [isa_pkg::EXC_W-1:0] act_code);
      if (act_exc !== exp_exc) begin
         report_mismatch("issue_pkt.exception", 32'(exp_exc), 32'(act_exc));
      end
      if (act_code !== exp_code) begin
         report_mismatch("issue_pkt.exccode", 32'(exp_code), 32'(act_code));
      end
   endtask

   // copied payload fields plus the write port request
   task automatic check_issue(input pipe_pkg::issue_pkt_t exp, input pipe_pkg::issue_pkt_t act);
      if (act.pc !== exp.pc) begin
         report_mismatch("issue_pkt.pc", exp.pc, act.pc);
      end
      if (act.inst !== exp.inst) begin
         report_mismatch("issue_pkt.inst", 32'(exp.inst), 32'(act.inst));
      end
      if (act.br_target !== exp.br_target) begin
         report_mismatch("issue_pkt.br_target", 32'(exp.br_target), 32'(act.br_target));
      end
      if (act.br_taken !== exp.br_taken) begin
         report_mismatch("issue_pkt.br_taken", 32'(exp.br_taken), 32'(act.br_taken));
      end
      if (act.hint !== exp.hint) begin
         report_mismatch("issue_pkt.hint", 32'(exp.hint), 32'(act.hint));
      end
      if (act.rf_wen !== exp.rf_wen) begin
         report_mismatch("issue_pkt.rf_wen", 32'(exp.rf_wen), 32'(act.rf_wen));
      end
      if (act.rf_target !== exp.rf_target) begin
         report_mismatch("issue_pkt.rf_target", 32'(exp.rf_target), 32'(act.rf_target));
      end
   endtask

   // expected payload part from the payload register model
   function automatic pipe_pkg::issue_pkt_t payload_view(input logic wen,
                                                          input logic [4:0] target);
      pipe_pkg::issue_pkt_t p;
      p           = '0;
      p.pc        = exp_pay.pc;
      p.inst      = exp_pay.inst;
      p.br_target = exp_pay.br_target;
      p.br_taken  = exp_pay.br_taken;
      p.hint      = exp_pay.hint;
      p.rf_wen    = wen;
      p.rf_target = target;
      return p;
   endfunction

   task automatic go_idle();
      fetch_valid = 1'b0;
      stall       = 1'b0;
      int_except  = 1'b0;
   endtask

   task automatic drive_row(input int r);
      int b;
      b = r * NUM_COLS;
      fetch_valid         = vec_mem[b][0];
      stall               = vec_mem[b+1][0];
      int_except          = vec_mem[b+2][0];
      fetch_pkt.pc        = vec_mem[b+3];
      fetch_pkt.inst      = isa_pkg::inst_word_u'(vec_mem[b+4]);
      fetch_pkt.br_target = vec_mem[b+5][pipe_pkg::GRLEN-3:0];
      fetch_pkt.br_taken  = vec_mem[b+6][0];
      fetch_pkt.exception = vec_mem[b+7][0];
      fetch_pkt.exccode   = vec_mem[b+8][isa_pkg::EXC_W-1:0];
      fetch_pkt.hint      = vec_mem[b+9][pipe_pkg::HINT_W-1:0];
      // packet only taken without stall
      if (fetch_valid && !stall) begin
         exp_pay = fetch_pkt;
         loaded  = 1'b1;
      end
   endtask

   task automatic check_row(input int r);
      int b;
      isa_pkg::dec_op_t exp_op;
      b = r * NUM_COLS + 10;
      check_valid("issue_valid", vec_mem[b][0], issue_valid);
      check_valid("dec_valid", vec_mem[b][0], dec_valid);
      // payload and op are unknown until the first load
      if (loaded) begin
         exp_op.op_class = isa_pkg::op_class_e'(vec_mem[b+1][2:0]);
         exp_op.bru_code = isa_pkg::bru_code_e'(vec_mem[b+2][1:0]);
         exp_op.gr_wen   = vec_mem[b+3][0];
         exp_op.dst_r1   = vec_mem[b+4][0];
         check_op(exp_op, issue_pkt.op);
         check_issue(payload_view(exp_op.gr_wen, vec_mem[b+5][4:0]), issue_pkt);
         check_exc(vec_mem[b+6][0], vec_mem[b+7][isa_pkg::EXC_W-1:0],
                   issue_pkt.exception, issue_pkt.exccode);
      end
   endtask

   // true when any of the three views hits a supported opcode
   function automatic logic in_subset(input isa_pkg::inst_word_u w);
      logic hit;
      hit = (w.reg3.opcode == isa_pkg::OP_ADD_W) || (w.reg3.opcode == isa_pkg::OP_SUB_W) ||
            (w.reg3.opcode == isa_pkg::OP_SYSCALL) || (w.reg3.opcode == isa_pkg::OP_BREAK) ||
            (w.reg2i12.opcode == isa_pkg::OP_ADDI_W) || (w.reg2i12.opcode == isa_pkg::OP_LD_W) ||
            (w.reg2i12.opcode == isa_pkg::OP_ST_W) ||
            (w.i26.opcode == isa_pkg::OP_B) || (w.i26.opcode == isa_pkg::OP_BL) ||
            (w.i26.opcode == isa_pkg::OP_BEQ) || (w.i26.opcode == isa_pkg::OP_BNE);
      return hit;
   endfunction

   task automatic drive_random();
      logic [31:0] word;
      logic [31:0] rnd;
      int          tries;
      tries = 0;
      word  = $random(seed);
      // redraw until the word misses the subset
      while (in_subset(isa_pkg::inst_word_u'(word)) && tries < WAIT_LIMIT) begin
         word = $random(seed);
         tries++;
      end
      if (in_subset(isa_pkg::inst_word_u'(word))) begin
         $display("no random word outside the decoded subset after %0d draws", tries);
         stop_run();
      end
      go_idle();
      fetch_valid         = 1'b1;
      fetch_pkt.pc        = $random(seed);
      fetch_pkt.inst      = isa_pkg::inst_word_u'(word);
      rnd                 = $random(seed);
      fetch_pkt.br_target = rnd[pipe_pkg::GRLEN-3:0];
      fetch_pkt.br_taken  = rnd[31];
      fetch_pkt.exception = 1'b0;
      fetch_pkt.exccode   = '0;
      fetch_pkt.hint      = rnd[pipe_pkg::GRLEN-2:pipe_pkg::GRLEN-1-pipe_pkg::HINT_W];
      exp_pay             = fetch_pkt;
   endtask

   // invalid word gives INE and no write
   task automatic check_random();
      isa_pkg::dec_op_t exp_op;
      exp_op.op_class = isa_pkg::CLS_INVALID;
      exp_op.bru_code = isa_pkg::BRU_NONE;
      exp_op.gr_wen   = 1'b0;
      exp_op.dst_r1   = 1'b0;
      check_op(exp_op, issue_pkt.op);
      check_issue(payload_view(1'b0, 5'd0), issue_pkt);
      check_exc(1'b1, isa_pkg::EXC_INE, issue_pkt.exception, issue_pkt.exccode);
   endtask

   task automatic wait_issue();
      int cnt;
      cnt = 0;
      do begin
         @(posedge clk);
         #1;
         cnt++;
      end while (issue_valid !== 1'b1 && cnt < WAIT_LIMIT);
      if (issue_valid !== 1'b1) begin
         $display("timeout, issue_valid never rose for pc %h", fetch_pkt.pc);
         stop_run();
      end
   endtask

   task automatic wait_reset_low();
      int cnt;
      cnt = 0;
      while ((issue_valid !== 1'b0 || dec_valid !== 1'b0) && cnt < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         cnt++;
      end
      if (issue_valid !== 1'b0 || dec_valid !== 1'b0) begin
         $display("timeout, issue_valid or dec_valid still high after reset");
         stop_run();
      end
   endtask

   initial begin
      rst         = 1'b1;
      // fetch offers a packet throughout reset
      // so only rst can keep the valid flop low
      fetch_valid = 1'b1;
      stall       = 1'b0;
      int_except  = 1'b0;
      fetch_pkt   = '0;
      exp_pay     = '0;
      loaded      = 1'b0;
      seed        = 32'heedd;
      $readmemh("testbench/ifu_dec_testdata.txt", vec_mem);
      repeat (16) @(posedge clk);
      #10;
      rst         = 1'b0;
      // stall freezes whatever reset left in the valid flop
      stall       = 1'b1;
      fetch_valid = 1'b0;
      wait_reset_low();
      @(posedge clk);
      #10;
      // row k is driven after one edge and checked just after the next
      drive_row(0);
      for (int r = 0; r < NUM_ROWS; r++) begin
         @(posedge clk);
         #1;
         check_row(r);
         #9;
         if (r + 1 < NUM_ROWS) begin
            drive_row(r + 1);
         end else begin
            go_idle();
         end
      end
      // one bubble edge before each random word
      for (int n = 0; n < NUM_RAND; n++) begin
         @(posedge clk);
         #10;
         drive_random();
         wait_issue();
         check_random();
         #9;
         fetch_valid = 1'b0;
      end
      $display("Everything OK");
      $finish;
   end

endmodule

// ==== verilog/dec_issue_merge.sv ====
module dec_issue_merge (
   // registered fetch packet
   input  pipe_pkg::fetch_pkt_t payload,
   // registered decode record
   input  isa_pkg::dec_op_t     op,
   // interrupt pending, acts in the issue cycle
   input  logic                 int_except,
   output pipe_pkg::issue_pkt_t issue_pkt
);

   // decode-side faults
   logic is_sys;
   logic is_brk;
   logic is_ine;

   // write target before masking
   logic [isa_pkg::RD_W-1:0] waddr;

   assign is_sys = op.op_class == isa_pkg::CLS_SYSCALL;
   assign is_brk = op.op_class == isa_pkg::CLS_BRK;
   assign is_ine = op.op_class == isa_pkg::CLS_INVALID;

   // BL links to r1, everything else writes rd
   assign waddr = op.dst_r1 ? 5'd1 : payload.inst.reg3.rd;

   always_comb begin
      // straight copies from the fetch packet
      issue_pkt.pc        = payload.pc;
      issue_pkt.inst      = payload.inst;
      issue_pkt.br_target = payload.br_target;
      issue_pkt.br_taken  = payload.br_taken;
      issue_pkt.hint      = payload.hint;
      issue_pkt.op        = op;

      // zero target when nothing is written
      issue_pkt.rf_wen    = op.gr_wen;
      issue_pkt.rf_target = {isa_pkg::RD_W{op.gr_wen}} & waddr;

      issue_pkt.exception = int_except | payload.exception | is_sys | is_brk | is_ine;

      // highest priority first
      // interrupt, then fetch fault, then decode faults
      if (int_except) begin
         issue_pkt.exccode = isa_pkg::EXC_INT;
      end else if (payload.exception) begin
         // fetch supplies its own code
         issue_pkt.exccode = payload.exccode;
      end else if (is_sys) begin
         issue_pkt.exccode = isa_pkg::EXC_SYS;
      end else if (is_brk) begin
         issue_pkt.exccode = isa_pkg::EXC_BRK;
      end else if (is_ine) begin
         issue_pkt.exccode = isa_pkg::EXC_INE;
      end else begin
         issue_pkt.exccode = '0;
      end
   end

endmodule

// ==== verilog/dec_pipe_reg.sv ====
module dec_pipe_reg (
   input  logic                 clk,
   input  logic                 rst,
   // fetch side
   input  logic                 fetch_valid,
   input  pipe_pkg::fetch_pkt_t fetch_pkt,
   // execute side backpressure
   input  logic                 stall,
   // capture strobe, shared with the decoder
   output logic                 load,
   output pipe_pkg::fetch_pkt_t payload,
   output logic                 issue_valid
);

   // new packet accepted only when execute is not holding us
   // fetch data offered during a stall is simply dropped
   assign load = fetch_valid & ~stall;

   // valid bit
   // bubble when fetch_valid low and no stall
   // held as is while stall is high
   always_ff @(posedge clk) begin
      if (rst) begin
         issue_valid <= 1'b0;
      end else if (!stall) begin
         issue_valid <= fetch_valid;
      end
   end

   // fetch payload
   // only written on load, keeps old contents through bubbles
   always_ff @(posedge clk) begin
      if (load) begin
         payload <= fetch_pkt;
      end
   end

endmodule

// ==== verilog/ifu_dec_top.sv ====
module ifu_dec_top (
   input  logic                 clk,
   input  logic                 rst,
   // from fetch
   input  logic                 fetch_valid,
   input  pipe_pkg::fetch_pkt_t fetch_pkt,
   // busy indication back to fetch
   output logic                 dec_valid,
   // interrupt level
   input  logic                 int_except,
   // to execute
   output logic                 issue_valid,
   output pipe_pkg::issue_pkt_t issue_pkt,
   // from execute
   input  logic                 stall
);

   // shared capture strobe
   logic                 load;
   // registered fetch packet
   pipe_pkg::fetch_pkt_t payload;
   // registered decode record
   isa_pkg::dec_op_t     op;

   // valid and payload registers, owns the stall logic
   dec_pipe_reg i_pipe_reg (
      .clk         (clk),
      .rst         (rst),
      .fetch_valid (fetch_valid),
      .fetch_pkt   (fetch_pkt),
      .stall       (stall),
      .load        (load),
      .payload     (payload),
      .issue_valid (issue_valid)
   );

   // decodes the incoming word, registered on the same load
   inst_decoder i_decoder (
      .clk  (clk),
      .inst (fetch_pkt.inst),
      .load (load),
      .op   (op)
   );

   // write target and exception selection
   dec_issue_merge i_merge (
      .payload    (payload),
      .op         (op),
      .int_except (int_except),
      .issue_pkt  (issue_pkt)
   );

   // fetch sees decode as busy whenever a packet is held
   assign dec_valid = issue_valid;

endmodule

// ==== verilog/inst_decoder.sv ====
module inst_decoder (
   input  logic                clk,
   // raw word from the fetch packet
   input  isa_pkg::inst_word_u inst,
   // same strobe that loads the payload register
   input  logic                load,
   output isa_pkg::dec_op_t    op
);

   // opcode matches, one per supported instruction
   logic is_add_w;
   logic is_sub_w;
   logic is_syscall;
   logic is_break;
   logic is_addi_w;
   logic is_ld_w;
   logic is_st_w;
   logic is_b;
   logic is_bl;
   logic is_beq;
   logic is_bne;

   // decoded record before the register
   isa_pkg::dec_op_t op_nxt;

   // reg3 view, 17-bit opcode
   assign is_add_w   = inst.reg3.opcode == isa_pkg::OP_ADD_W;
   assign is_sub_w   = inst.reg3.opcode == isa_pkg::OP_SUB_W;
   assign is_syscall = inst.reg3.opcode == isa_pkg::OP_SYSCALL;
   assign is_break   = inst.reg3.opcode == isa_pkg::OP_BREAK;

   // reg2i12 view, 10-bit opcode
   assign is_addi_w = inst.reg2i12.opcode == isa_pkg::OP_ADDI_W;
   assign is_ld_w   = inst.reg2i12.opcode == isa_pkg::OP_LD_W;
   assign is_st_w   = inst.reg2i12.opcode == isa_pkg::OP_ST_W;

   // i26 view, 6-bit prefix
   assign is_b   = inst.i26.opcode == isa_pkg::OP_B;
   assign is_bl  = inst.i26.opcode == isa_pkg::OP_BL;
   assign is_beq = inst.i26.opcode == isa_pkg::OP_BEQ;
   assign is_bne = inst.i26.opcode == isa_pkg::OP_BNE;

   // classify
   // encodings are disjoint so the order of the chain does not matter
   always_comb begin
      // anything not matched below is INE
      op_nxt.op_class = isa_pkg::CLS_INVALID;
      op_nxt.bru_code = isa_pkg::BRU_NONE;
      op_nxt.gr_wen   = 1'b0;
      op_nxt.dst_r1   = 1'b0;
      if (is_add_w || is_sub_w || is_addi_w) begin
         op_nxt.op_class = isa_pkg::CLS_ALU;
         op_nxt.gr_wen   = 1'b1;
      end else if (is_ld_w) begin
         op_nxt.op_class = isa_pkg::CLS_LOAD;
         op_nxt.gr_wen   = 1'b1;
      end else if (is_st_w) begin
         // store reads rd as data, no write back
         op_nxt.op_class = isa_pkg::CLS_STORE;
      end else if (is_b) begin
         op_nxt.op_class = isa_pkg::CLS_BRANCH;
         op_nxt.bru_code = isa_pkg::BRU_B;
      end else if (is_bl) begin
         // link register is r1
         op_nxt.op_class = isa_pkg::CLS_BRANCH;
         op_nxt.bru_code = isa_pkg::BRU_BL;
         op_nxt.gr_wen   = 1'b1;
         op_nxt.dst_r1   = 1'b1;
      end else if (is_beq || is_bne) begin
         op_nxt.op_class = isa_pkg::CLS_BRANCH;
         op_nxt.bru_code = isa_pkg::BRU_COND;
      end else if (is_syscall) begin
         op_nxt.op_class = isa_pkg::CLS_SYSCALL;
      end else if (is_break) begin
         op_nxt.op_class = isa_pkg::CLS_BRK;
      end
   end

   // operation register, loaded in step with the payload
   // holds through stalls and bubbles
   always_ff @(posedge clk) begin
      if (load) begin
         op <= op_nxt;
      end
   end

endmodule

// ==== verilog/isa_pkg.sv ====
package isa_pkg;

   // register index and exception code widths
   localparam int RD_W  = 5;
   localparam int EXC_W = 6;

   // three-register view
   // syscall and break reuse it, their code sits in rk/rj/rd
   typedef struct packed {
      logic [16:0]     opcode;
      logic [RD_W-1:0] rk;
      logic [RD_W-1:0] rj;
      logic [RD_W-1:0] rd;
   } fmt_reg3_t;

   // two registers plus 12-bit immediate
   typedef struct packed {
      logic [9:0]      opcode;
      logic [11:0]     imm;
      logic [RD_W-1:0] rj;
      logic [RD_W-1:0] rd;
   } fmt_reg2i12_t;

   // branch prefix view
   // BEQ/BNE still carry rj/rd in the low bits of offs
   typedef struct packed {
      logic [5:0]  opcode;
      logic [25:0] offs;
   } fmt_i26_t;

   // one instruction word, read through whichever format matches
   typedef union packed {
      fmt_reg3_t    reg3;
      fmt_reg2i12_t reg2i12;
      fmt_i26_t     i26;
   } inst_word_u;

   // reg3 opcodes, inst[31:15]
   localparam logic [16:0] OP_ADD_W   = 17'h00020;
   localparam logic [16:0] OP_SUB_W   = 17'h00022;
   localparam logic [16:0] OP_BREAK   = 17'h00054;
   localparam logic [16:0] OP_SYSCALL = 17'h00056;

   // reg2i12 opcodes, inst[31:22]
   localparam logic [9:0] OP_ADDI_W = 10'h00a;
   localparam logic [9:0] OP_LD_W   = 10'h0a2;
   localparam logic [9:0] OP_ST_W   = 10'h0a6;

   // i26 prefixes, inst[31:26]
   localparam logic [5:0] OP_B   = 6'h14;
   localparam logic [5:0] OP_BL  = 6'h15;
   localparam logic [5:0] OP_BEQ = 6'h16;
   localparam logic [5:0] OP_BNE = 6'h17;

   // exception codes, as seen by execute
   localparam logic [EXC_W-1:0] EXC_INT = 6'd0;
   localparam logic [EXC_W-1:0] EXC_SYS = 6'd11;
   localparam logic [EXC_W-1:0] EXC_BRK = 6'd12;
   localparam logic [EXC_W-1:0] EXC_INE = 6'd13;

   typedef enum logic [2:0] {
      CLS_ALU,
      CLS_LOAD,
      CLS_STORE,
      CLS_BRANCH,
      CLS_SYSCALL,
      CLS_BRK,
      CLS_INVALID
   } op_class_e;

   typedef enum logic [1:0] {
      BRU_NONE,
      BRU_B,
      BRU_BL,
      BRU_COND
   } bru_code_e;

   // decoded operation record, 7 bits
   typedef struct packed {
      op_class_e op_class;
      bru_code_e bru_code;
      logic      gr_wen;
      // BL links into r1 instead of rd
      logic      dst_r1;
   } dec_op_t;

endpackage

// ==== verilog/pipe_pkg.sv ====
package pipe_pkg;

   // integer register width
   localparam int GRLEN = 32;

   // branch predictor hint width
   localparam int HINT_W = 4;

   // what fetch hands to decode each cycle
   typedef struct packed {
      logic [GRLEN-1:0]              pc;
      isa_pkg::inst_word_u           inst;
      // target is word aligned, low two bits dropped
      logic [GRLEN-3:0]              br_target;
      logic                          br_taken;
      // fault seen on the fetch side
      logic                          exception;
      logic [isa_pkg::EXC_W-1:0]     exccode;
      logic [HINT_W-1:0]             hint;
   } fetch_pkt_t;

   // what decode hands to execute
   typedef struct packed {
      logic [GRLEN-1:0]              pc;
      isa_pkg::inst_word_u           inst;
      isa_pkg::dec_op_t              op;
      logic [GRLEN-3:0]              br_target;
      logic                          br_taken;
      // fetch fault merged with decode-side faults
      logic                          exception;
      logic [isa_pkg::EXC_W-1:0]     exccode;
      // register file write port request
      logic                          rf_wen;
      logic [isa_pkg::RD_W-1:0]      rf_target;
      logic [HINT_W-1:0]             hint;
   } issue_pkt_t;

endpackage
